//--- hw/rv_pkg.sv
package rv_pkg;

    localparam int xlen = 32;
    localparam int reg_count = 32;
    localparam logic [xlen-1:0] reset_address = 32'h0000_0000;

    typedef logic [xlen-1:0] word_t;
    typedef logic [4:0] reg_index_t;

    // ------------------------------
    // Opcodes and function codes
    // ------------------------------
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111
    } opcode_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA
    } alu_op_t;

    typedef enum logic [1:0] {
        BEQ = 2'b00,
        BNE = 2'b01,
        BLT = 2'b10,
        BGE = 2'b11
    } branch_op_t;

    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_sll     = 3'b001;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_sltu    = 3'b011;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_srl_sra = 3'b101;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;
    localparam logic [2:0] f3_bne     = 3'b001;
    localparam logic [2:0] f3_blt     = 3'b100;
    localparam logic [2:0] f3_bge     = 3'b101;

    // SUB and SRA/SRAI
    localparam logic [6:0] funct7_alt = 7'b0100000;

    // ------------------------------
    // Instruction formats
    // ------------------------------
    typedef struct packed {
        logic [6:0] funct7;
        reg_index_t rs2;
        reg_index_t rs1;
        logic [2:0] funct3;
        reg_index_t rd;
        opcode_t    opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        reg_index_t  rs1;
        logic [2:0]  funct3;
        reg_index_t  rd;
        opcode_t     opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        reg_index_t rs2;
        reg_index_t rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        opcode_t    opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        reg_index_t rs2;
        reg_index_t rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        opcode_t    opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        reg_index_t  rd;
        opcode_t     opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        reg_index_t rd;
        opcode_t    opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } instr_u;

    // ------------------------------
    // Stage records
    // ------------------------------
    typedef struct packed {
        opcode_t    opcode;
        alu_op_t    alu_op;
        branch_op_t branch_op;
        logic       use_imm;
        reg_index_t rs1;
        reg_index_t rs2;
        reg_index_t rd;
        logic       read_enable_1;
        logic       read_enable_2;
        logic       write_enable;
        word_t      immediate;
    } decoded_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        decoded_t decoded;
        word_t    rs1_value;
        word_t    rs2_value;
    } ex_stage_t;

    typedef struct packed {
        logic       valid;
        opcode_t    opcode;
        reg_index_t rd;
        logic       write_enable;
        word_t      result;
        word_t      address;
        word_t      store_data;
    } mem_stage_t;

    typedef struct packed {
        logic       write_enable;
        reg_index_t rd;
        word_t      write_data;
    } wb_stage_t;

    typedef struct packed {
        logic  enable;
        logic  write;
        word_t address;
        word_t write_data;
    } dmem_req_t;

endpackage

//--- hw/instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder (
    input  rv_pkg::instr_u   instr,
    output rv_pkg::decoded_t decoded
);
    import rv_pkg::*;

    logic alt;

    assign alt = (instr.r_fmt.funct7 == funct7_alt);

    function automatic alu_op_t alu_select(logic [2:0] funct3, logic is_reg);
        alu_op_t op;
        case (funct3)
            f3_add_sub : op = (alt && is_reg) ? ALU_SUB : ALU_ADD;
            f3_sll     : op = ALU_SLL;
            f3_slt     : op = ALU_SLT;
            f3_sltu    : op = ALU_SLTU;
            f3_xor     : op = ALU_XOR;
            f3_srl_sra : op = alt ? ALU_SRA : ALU_SRL;
            f3_or      : op = ALU_OR;
            default    : op = ALU_AND;
        endcase
        return op;
    endfunction

    always_comb
    begin
        decoded = '0;
        decoded.opcode = instr.r_fmt.opcode;
        decoded.alu_op = ALU_ADD;
        decoded.branch_op = BEQ;
        decoded.rs1 = instr.r_fmt.rs1;
        decoded.rs2 = instr.r_fmt.rs2;
        decoded.rd = instr.r_fmt.rd;

        case (instr.r_fmt.opcode)
            OP :
            begin
                decoded.alu_op = alu_select(instr.r_fmt.funct3, 1'b1);
                decoded.read_enable_1 = 1'b1;
                decoded.read_enable_2 = 1'b1;
                decoded.write_enable = 1'b1;
            end
            OP_IMM, LOAD :
            begin
                if (instr.i_fmt.opcode == OP_IMM)
                    decoded.alu_op = alu_select(instr.i_fmt.funct3, 1'b0);
                decoded.use_imm = 1'b1;
                decoded.read_enable_1 = 1'b1;
                decoded.write_enable = 1'b1;
                decoded.immediate = {{20{instr.i_fmt.imm_11_0[11]}}, instr.i_fmt.imm_11_0};
            end
            LUI :
            begin
                decoded.use_imm = 1'b1;
                decoded.write_enable = 1'b1;
                decoded.immediate = {instr.u_fmt.imm_31_12, 12'b0};
            end
            STORE :
            begin
                decoded.use_imm = 1'b1;
                decoded.read_enable_1 = 1'b1;
                decoded.read_enable_2 = 1'b1;
                decoded.immediate = {{20{instr.s_fmt.imm_11_5[6]}}, instr.s_fmt.imm_11_5,
                                     instr.s_fmt.imm_4_0};
            end
            BRANCH :
            begin
                case (instr.b_fmt.funct3)
                    f3_bne  : decoded.branch_op = BNE;
                    f3_blt  : decoded.branch_op = BLT;
                    f3_bge  : decoded.branch_op = BGE;
                    default : decoded.branch_op = BEQ;
                endcase
                decoded.read_enable_1 = 1'b1;
                decoded.read_enable_2 = 1'b1;
                decoded.immediate = {{19{instr.b_fmt.imm_12}}, instr.b_fmt.imm_12,
                                     instr.b_fmt.imm_11, instr.b_fmt.imm_10_5,
                                     instr.b_fmt.imm_4_1, 1'b0};
            end
            JAL :
            begin
                decoded.write_enable = 1'b1;
                decoded.immediate = {{11{instr.j_fmt.imm_20}}, instr.j_fmt.imm_20,
                                     instr.j_fmt.imm_19_12, instr.j_fmt.imm_11,
                                     instr.j_fmt.imm_10_1, 1'b0};
            end
            // Anything else travels as a bubble
            default : decoded.write_enable = 1'b0;
        endcase

        // x0 is never a destination
        if (decoded.rd == '0)
            decoded.write_enable = 1'b0;
    end

endmodule

//--- hw/register_file.sv
`timescale 1ns/1ps

module register_file (
    input  logic              clk,
    input  logic              reset,
    input  rv_pkg::reg_index_t read_index_1,
    input  rv_pkg::reg_index_t read_index_2,
    output rv_pkg::word_t     read_data_1,
    output rv_pkg::word_t     read_data_2,
    input  rv_pkg::wb_stage_t write
);
    import rv_pkg::*;

    word_t regs [reg_count];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < reg_count; i++)
                regs[i] <= '0;
        end
        else if (write.write_enable && write.rd != '0)
            regs[write.rd] <= write.write_data;
    end

    // Same-cycle write is visible to decode
    function automatic word_t read_port(reg_index_t index);
        if (index == '0)
            return '0;
        if (write.write_enable && write.rd == index)
            return write.write_data;
        return regs[index];
    endfunction

    always_comb
    begin
        read_data_1 = read_port(read_index_1);
        read_data_2 = read_port(read_index_2);
    end

endmodule

//--- hw/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit (
    input  rv_pkg::decoded_t   decoded,
    input  rv_pkg::word_t      rf_data_1,
    input  rv_pkg::word_t      rf_data_2,
    input  rv_pkg::ex_stage_t  ex_stage,
    input  rv_pkg::word_t      ex_result,
    input  rv_pkg::mem_stage_t mem_stage,
    input  rv_pkg::word_t      mem_load_data,
    input  rv_pkg::wb_stage_t  wb_stage,
    output rv_pkg::word_t      operand_1,
    output rv_pkg::word_t      operand_2,
    output logic               load_stall
);
    import rv_pkg::*;

    word_t mem_data;
    logic  ex_writes;

    assign ex_writes = ex_stage.valid && ex_stage.decoded.write_enable;
    assign mem_data = (mem_stage.opcode == LOAD) ? mem_load_data : mem_stage.result;

    // Youngest writer wins
    function automatic word_t select_operand(reg_index_t source, logic read_enable,
                                             word_t rf_value);
        word_t value;
        value = rf_value;
        if (read_enable && source != '0)
        begin
            if (ex_writes && ex_stage.decoded.rd == source)
                value = ex_result;
            else if (mem_stage.write_enable && mem_stage.rd == source)
                value = mem_data;
            else if (wb_stage.write_enable && wb_stage.rd == source)
                value = wb_stage.write_data;
        end
        return value;
    endfunction

    always_comb
    begin
        operand_1 = select_operand(decoded.rs1, decoded.read_enable_1, rf_data_1);
        operand_2 = select_operand(decoded.rs2, decoded.read_enable_2, rf_data_2);
    end

    // Load data is not ready until the memory stage
    assign load_stall = ex_writes && ex_stage.decoded.opcode == LOAD &&
        ((decoded.read_enable_1 && ex_stage.decoded.rd == decoded.rs1) ||
         (decoded.read_enable_2 && ex_stage.decoded.rd == decoded.rs2));

endmodule

//--- hw/execute_unit.sv
`timescale 1ns/1ps

module execute_unit (
    input  rv_pkg::ex_stage_t ex_stage,
    output rv_pkg::word_t     result,
    output rv_pkg::word_t     target,
    output rv_pkg::word_t     address,
    output logic              taken
);
    import rv_pkg::*;

    word_t      operand_a;
    word_t      operand_b;
    word_t      alu_out;
    logic [4:0] shamt;
    logic       equal;
    logic       less;
    logic       condition;

    assign operand_a = ex_stage.rs1_value;
    assign operand_b = ex_stage.decoded.use_imm ? ex_stage.decoded.immediate
                                                : ex_stage.rs2_value;
    assign shamt = operand_b[4:0];

    // ------------------------------
    // ALU
    // ------------------------------
    always_comb
    begin
        case (ex_stage.decoded.alu_op)
            ALU_ADD  : alu_out = operand_a + operand_b;
            ALU_SUB  : alu_out = operand_a - operand_b;
            ALU_AND  : alu_out = operand_a & operand_b;
            ALU_OR   : alu_out = operand_a | operand_b;
            ALU_XOR  : alu_out = operand_a ^ operand_b;
            ALU_SLT  : alu_out = {{(xlen-1){1'b0}}, $signed(operand_a) < $signed(operand_b)};
            ALU_SLTU : alu_out = {{(xlen-1){1'b0}}, operand_a < operand_b};
            ALU_SLL  : alu_out = operand_a << shamt;
            ALU_SRL  : alu_out = operand_a >> shamt;
            default  : alu_out = $signed(operand_a) >>> shamt;
        endcase
    end

    always_comb
    begin
        case (ex_stage.decoded.opcode)
            LUI     : result = ex_stage.decoded.immediate;
            // Link value for JAL
            JAL     : result = ex_stage.pc + word_t'(4);
            default : result = alu_out;
        endcase
    end

    // ------------------------------
    // Branch resolution
    // ------------------------------
    assign equal = (ex_stage.rs1_value == ex_stage.rs2_value);
    assign less = ($signed(ex_stage.rs1_value) < $signed(ex_stage.rs2_value));

    always_comb
    begin
        case (ex_stage.decoded.branch_op)
            BEQ     : condition = equal;
            BNE     : condition = !equal;
            BLT     : condition = less;
            default : condition = !less;
        endcase
    end

    assign target = ex_stage.pc + ex_stage.decoded.immediate;
    assign address = ex_stage.rs1_value + ex_stage.decoded.immediate;
    assign taken = ex_stage.valid && (ex_stage.decoded.opcode == JAL ||
                   (ex_stage.decoded.opcode == BRANCH && condition));

endmodule

//--- hw/rv_core.sv
`timescale 1ns/1ps

module rv_core (
    input  logic              clk,
    input  logic              reset,
    output rv_pkg::word_t     imem_addr,
    input  rv_pkg::word_t     imem_data,
    output rv_pkg::dmem_req_t dmem_req,
    input  rv_pkg::word_t     dmem_rdata
);
    import rv_pkg::*;

    word_t      pc;
    logic       id_valid;
    word_t      id_pc;
    instr_u     id_instr;
    decoded_t   decoded;
    word_t      rf_data_1;
    word_t      rf_data_2;
    word_t      operand_1;
    word_t      operand_2;
    logic       load_stall;
    ex_stage_t  ex_stage;
    word_t      ex_result;
    word_t      ex_target;
    word_t      ex_address;
    logic       taken;
    mem_stage_t mem_stage;
    wb_stage_t  wb_stage;
    word_t      wb_data;

    // ------------------------------
    // Fetch
    // ------------------------------
    assign imem_addr = pc;

    always_ff @(posedge clk)
    begin
        if (reset)
            pc <= reset_address;
        else if (taken)
            pc <= ex_target;
        else if (!load_stall)
            pc <= pc + word_t'(4);
    end

    // ------------------------------
    // Decode
    // ------------------------------
    always_ff @(posedge clk)
    begin
        if (reset || taken)
            id_valid <= 1'b0;
        else if (!load_stall)
            id_valid <= 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (!load_stall)
        begin
            id_pc <= pc;
            id_instr <= imem_data;
        end
    end

    instr_decoder instr_decoder (
        .instr   (id_instr),
        .decoded (decoded)
    );

    register_file register_file (
        .clk          (clk),
        .reset        (reset),
        .read_index_1 (decoded.rs1),
        .read_index_2 (decoded.rs2),
        .read_data_1  (rf_data_1),
        .read_data_2  (rf_data_2),
        .write        (wb_stage)
    );

    hazard_unit hazard_unit (
        .decoded       (decoded),
        .rf_data_1     (rf_data_1),
        .rf_data_2     (rf_data_2),
        .ex_stage      (ex_stage),
        .ex_result     (ex_result),
        .mem_stage     (mem_stage),
        .mem_load_data (dmem_rdata),
        .wb_stage      (wb_stage),
        .operand_1     (operand_1),
        .operand_2     (operand_2),
        .load_stall    (load_stall)
    );

    // ------------------------------
    // Execute
    // ------------------------------
    // Flush and load-use both leave a bubble here
    always_ff @(posedge clk)
    begin
        if (reset || taken || load_stall)
            ex_stage.valid <= 1'b0;
        else
            ex_stage <= '{valid: id_valid, pc: id_pc, decoded: decoded,
                          rs1_value: operand_1, rs2_value: operand_2};
    end

    execute_unit execute_unit (
        .ex_stage (ex_stage),
        .result   (ex_result),
        .target   (ex_target),
        .address  (ex_address),
        .taken    (taken)
    );

    // ------------------------------
    // Memory
    // ------------------------------
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            mem_stage.valid <= 1'b0;
            mem_stage.write_enable <= 1'b0;
        end
        else
            mem_stage <= '{valid: ex_stage.valid,
                           opcode: ex_stage.decoded.opcode,
                           rd: ex_stage.decoded.rd,
                           write_enable: ex_stage.valid && ex_stage.decoded.write_enable,
                           result: ex_result,
                           address: ex_address,
                           store_data: ex_stage.rs2_value};
    end

    assign dmem_req.enable = mem_stage.valid &&
                             (mem_stage.opcode == LOAD || mem_stage.opcode == STORE);
    assign dmem_req.write = (mem_stage.opcode == STORE);
    assign dmem_req.address = mem_stage.address;
    assign dmem_req.write_data = mem_stage.store_data;

    // ------------------------------
    // Writeback
    // ------------------------------
    // JAL result already carries pc + 4
    assign wb_data = (mem_stage.opcode == LOAD) ? dmem_rdata : mem_stage.result;

    always_ff @(posedge clk)
    begin
        if (reset)
            wb_stage.write_enable <= 1'b0;
        else
            wb_stage <= '{write_enable: mem_stage.write_enable, rd: mem_stage.rd,
                          write_data: wb_data};
    end

    // No data access once reset has been seen on an edge
    assert property (@(posedge clk) reset && $past(reset) |-> !dmem_req.enable)
        else $error("data request issued during reset");

    // Every data access is a full word
    assert property (@(posedge clk) disable iff (reset)
        dmem_req.enable |-> dmem_req.address[1:0] == 2'b00)
        else $error("misaligned data access");

endmodule

//--- testbench/tb_programs.svh
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

localparam int    test_count = 7;
localparam int    max_words = 128;
localparam int    max_stores = 32;
localparam word_t halt_address = 32'h0000_03fc;
localparam word_t result_base = 32'h0000_0100;

string     test_name [test_count];
word_t     program_words [test_count][max_words];
int        program_len [test_count];
dmem_req_t expected_stores [test_count][max_stores];
int        expected_len [test_count];
int        building;
int        result_slot;

// ------------------------------
// Instruction encodings
// ------------------------------
function automatic word_t r_type(logic [6:0] funct7, reg_index_t rs2, reg_index_t rs1,
                                 logic [2:0] funct3, reg_index_t rd);
    return {funct7, rs2, rs1, funct3, rd, 7'b0110011};
endfunction

function automatic word_t i_type(logic [6:0] opcode, logic [11:0] imm, reg_index_t rs1,
                                 logic [2:0] funct3, reg_index_t rd);
    return {imm, rs1, funct3, rd, opcode};
endfunction

// Word store, base register x0 in every program
function automatic word_t s_type(logic [11:0] imm, reg_index_t rs2, reg_index_t rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
endfunction

function automatic word_t b_type(logic [2:0] funct3, reg_index_t rs1, reg_index_t rs2,
                                 logic [12:0] offset);
    return {offset[12], offset[10:5], rs2, rs1, funct3, offset[4:1], offset[11],
            7'b1100011};
endfunction

function automatic word_t u_type(logic [19:0] imm, reg_index_t rd);
    return {imm, rd, 7'b0110111};
endfunction

function automatic word_t j_type(reg_index_t rd, logic [20:0] offset);
    return {offset[20], offset[10:1], offset[11], offset[19:12], rd, 7'b1101111};
endfunction

// ------------------------------
// Program building
// ------------------------------
task automatic emit(input word_t instr);
    program_words[building][program_len[building]] = instr;
    program_len[building]++;
endtask

// Stores that sit in a flushed shadow are emitted but not expected
task automatic store_word(input reg_index_t rs, input word_t addr, input word_t value,
                          input logic fires);
    emit(s_type(addr[11:0], rs, 5'd0));
    if (fires)
    begin
        expected_stores[building][expected_len[building]] =
            '{enable: 1'b1, write: 1'b1, address: addr, write_data: value};
        expected_len[building]++;
    end
endtask

task automatic save_result(input reg_index_t rs, input word_t value, input logic fires);
    store_word(rs, result_base + word_t'(4 * result_slot), value, fires);
    result_slot++;
endtask

// LUI then a dependent ADDI; the low part is sign-extended before the add
task automatic load_const(input reg_index_t rd, output word_t value);
    logic [19:0] upper;
    logic [11:0] lower;
    upper = 20'(next_random());
    lower = 12'(next_random());
    emit(u_type(upper, rd));
    emit(i_type(7'b0010011, lower, rd, 3'b000, rd));
    value = {upper, 12'h000} + {{20{lower[11]}}, lower};
endtask

task automatic start_program(input string name);
    test_name[building] = name;
    program_len[building] = 0;
    expected_len[building] = 0;
    result_slot = 0;
endtask

task automatic finish_program();
    store_word(5'd0, halt_address, '0, 1'b1);
    building++;
endtask

task automatic build_tables();
    word_t       a;
    word_t       b;
    word_t       c;
    word_t       lv;
    word_t       rv;
    logic [11:0] imm;
    logic [6:0]  hi;
    logic [2:0]  f3;
    logic        branch_taken;
    reg_index_t  lhs;
    reg_index_t  rhs;
    int          op;
    int          form;
    int          p;
    building = 0;

    // Ops 0..7 follow funct3, 8 is SUB and 9 is SRA
    start_program("alu_reg");
    for (int k = 0; k < 10; k++)
    begin
        f3 = (k < 8) ? 3'(k) : ((k == 8) ? 3'b000 : 3'b101);
        hi = (k >= 8) ? 7'b0100000 : 7'b0000000;
        load_const(5'd1, a);
        load_const(5'd2, b);
        emit(r_type(hi, 5'd2, 5'd1, f3, 5'd3));
        c = alu_rule(f3, hi[5], a, b);
        save_result(5'd3, c, 1'b1);
        // x3 from memory stage, x2 from writeback
        emit(r_type(7'b0000000, 5'd2, 5'd3, 3'b000, 5'd4));
        save_result(5'd4, c + b, 1'b1);
    end
    finish_program();

    start_program("alu_imm");
    for (int k = 0; k < 9; k++)
    begin
        f3 = (k < 8) ? 3'(k) : 3'b101;
        imm = 12'(next_random());
        if (f3 == 3'b001 || f3 == 3'b101)
            imm = {(k == 8) ? 7'b0100000 : 7'b0000000, imm[4:0]};
        load_const(5'd1, a);
        emit(i_type(7'b0010011, imm, 5'd1, f3, 5'd3));
        c = alu_rule(f3, k == 8, a, {{20{imm[11]}}, imm});
        save_result(5'd3, c, 1'b1);
    end
    finish_program();

    start_program("lui_addi");
    for (int k = 0; k < 6; k++)
    begin
        load_const(5'(k + 1), a);
        save_result(5'(k + 1), a, 1'b1);
    end
    finish_program();

    start_program("load_use");
    load_const(5'd1, a);
    load_const(5'd2, b);
    store_word(5'd1, 32'h0000_0080, a, 1'b1);
    emit(i_type(7'b0000011, 12'h080, 5'd0, 3'b010, 5'd3));
    emit(r_type(7'b0000000, 5'd2, 5'd3, 3'b000, 5'd4));
    save_result(5'd4, a + b, 1'b1);
    // Loaded value used at once as store data
    emit(i_type(7'b0000011, 12'h080, 5'd0, 3'b010, 5'd5));
    save_result(5'd5, a, 1'b1);
    finish_program();

    // Operand forms: (x1,x1), (x1,x2), (x2,x1)
    start_program("branch");
    for (int n = 0; n < 12; n++)
    begin
        op = n / 3;
        form = n % 3;
        f3 = (op < 2) ? 3'(op) : 3'(op + 2);
        load_const(5'd1, a);
        load_const(5'd2, b);
        lhs = (form == 2) ? 5'd2 : 5'd1;
        rhs = (form == 1) ? 5'd2 : 5'd1;
        lv = (form == 2) ? b : a;
        rv = (form == 1) ? b : a;
        branch_taken = branch_rule(f3, lv, rv);
        emit(b_type(f3, lhs, rhs, 13'd12));
        save_result(5'd1, a, !branch_taken);
        save_result(5'd2, b, !branch_taken);
    end
    finish_program();

    start_program("jal");
    load_const(5'd1, a);
    p = program_len[building] * 4;
    emit(j_type(5'd5, 21'd12));
    save_result(5'd1, a, 1'b0);
    save_result(5'd1, a, 1'b0);
    save_result(5'd5, word_t'(p + 4), 1'b1);
    emit(j_type(5'd0, 21'd12));
    save_result(5'd1, a, 1'b0);
    save_result(5'd1, a, 1'b0);
    save_result(5'd1, a, 1'b1);
    finish_program();

    start_program("x0_writes");
    load_const(5'd1, a);
    load_const(5'd2, b);
    emit(i_type(7'b0010011, 12'h555, 5'd0, 3'b000, 5'd0));
    save_result(5'd0, '0, 1'b1);
    emit(u_type(20'(next_random()), 5'd0));
    emit(r_type(7'b0000000, 5'd2, 5'd1, 3'b000, 5'd0));
    save_result(5'd0, '0, 1'b1);
    emit(r_type(7'b0000000, 5'd1, 5'd0, 3'b000, 5'd3));
    save_result(5'd3, a, 1'b1);
    finish_program();
endtask

`endif

//--- testbench/tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core;
    import rv_pkg::*;

    localparam int mem_words = 256;
    localparam int reset_cycles = 8;
    localparam int timeout_cycles = 1000;

    logic      clk;
    logic      reset;
    word_t     imem_addr;
    word_t     imem_data;
    dmem_req_t dmem_req;
    word_t     dmem_rdata;

    word_t     imem [mem_words];
    word_t     dmem [mem_words];
    dmem_req_t seen_stores [$];
    word_t     rng_state;
    int        store_errors;
    int        count_errors;
    int        timeouts;

    rv_core dut (
        .clk        (clk),
        .reset      (reset),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .dmem_req   (dmem_req),
        .dmem_rdata (dmem_rdata)
    );

    // ------------------------------
    // Reference rules
    // ------------------------------
    function automatic word_t next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // RV32I integer result by funct3, alt selects SUB or SRA
    function automatic word_t alu_rule(logic [2:0] funct3, logic alt, word_t a, word_t b);
        word_t r;
        case (funct3)
            3'b000  : r = alt ? a - b : a + b;
            3'b001  : r = a << b[4:0];
            3'b010  : r = {31'b0, $signed(a) < $signed(b)};
            3'b011  : r = {31'b0, a < b};
            3'b100  : r = a ^ b;
            3'b101  :
            begin
                if (alt)
                    r = word_t'($signed(a) >>> b[4:0]);
                else
                    r = a >> b[4:0];
            end
            3'b110  : r = a | b;
            default : r = a & b;
        endcase
        return r;
    endfunction

    function automatic logic branch_rule(logic [2:0] funct3, word_t a, word_t b);
        case (funct3)
            3'b000  : return a == b;
            3'b001  : return a != b;
            3'b100  : return $signed(a) < $signed(b);
            default : return $signed(a) >= $signed(b);
        endcase
    endfunction

`include "tb_programs.svh"

    // ------------------------------
    // Clock and memory models
    // ------------------------------
    initial
    begin
        clk = 1'b0;
        forever
            #2 clk = ~clk;
    end

    // Reads change on the falling edge and hold through the rising edge
    initial
    begin
        imem_data = '0;
        dmem_rdata = '0;
        forever
        begin
            @(negedge clk);
            imem_data = imem[imem_addr[9:2]];
            dmem_rdata = dmem[dmem_req.address[9:2]];
        end
    end

    always @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < mem_words; i++)
                dmem[i] <= '0;
            seen_stores.delete();
        end
        else if (dmem_req.enable && dmem_req.write)
        begin
            dmem[dmem_req.address[9:2]] <= dmem_req.write_data;
            seen_stores.push_back(dmem_req);
        end
    end

    // ------------------------------
    // Checks
    // ------------------------------
    task automatic check_store(input string label, input dmem_req_t expected,
                               input dmem_req_t actual);
        if (actual !== expected)
        begin
            store_errors++;
            $display("[ERROR] %s dmem_req expected %h got %h", label, expected, actual);
        end
    endtask

    task automatic check_count(input string label, input int expected, input int actual);
        if (actual != expected)
        begin
            count_errors++;
            $display("[ERROR] %s dmem_req store count expected %0h got %0h",
                     label, expected, actual);
        end
    endtask

    task automatic run_test(input int t);
        int   cycles;
        logic halted;
        @(negedge clk);
        reset = 1'b1;
        for (int i = 0; i < mem_words; i++)
        begin
            if (i < program_len[t])
                imem[i] = program_words[t][i];
            else
                imem[i] = '0;
        end
        repeat (reset_cycles) @(negedge clk);
        reset = 1'b0;

        cycles = 0;
        halted = 1'b0;
        while (!halted && cycles < timeout_cycles)
        begin
            @(negedge clk);
            cycles++;
            halted = seen_stores.size() > 0 && seen_stores[$].address == halt_address;
        end
        if (!halted)
        begin
            timeouts++;
            $display("Timeout: program %s did not reach its halt store within %0d cycles",
                     test_name[t], timeout_cycles);
        end

        check_count(test_name[t], expected_len[t], seen_stores.size());
        for (int i = 0; i < expected_len[t] && i < seen_stores.size(); i++)
            check_store($sformatf("%s store %0d", test_name[t], i),
                        expected_stores[t][i], seen_stores[i]);
    endtask

    initial
    begin
        reset = 1'b1;
        store_errors = 0;
        count_errors = 0;
        timeouts = 0;
        rng_state = 32'h0000_80da;
        build_tables();
        for (int t = 0; t < test_count; t++)
            run_test(t);
        $display("Store mismatches %0d, count mismatches %0d, timeouts %0d",
                 store_errors, count_errors, timeouts);
        if (store_errors + count_errors + timeouts == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

//--- flist.f
+incdir+testbench
hw/rv_pkg.sv
hw/instr_decoder.sv
hw/register_file.sv
hw/hazard_unit.sv
hw/execute_unit.sv
hw/rv_core.sv
testbench/tb_rv_core.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the pipeline regression, result decided from sim.log
set -o pipefail
cd "$(dirname "$0")" || exit 1
verilator --binary -f flist.f --top-module tb_rv_core -o tb_rv_core \
    && ./obj_dir/tb_rv_core | tee sim.log \
    || { echo "Build or simulation did not complete"; exit 1; }
grep -q "Regression failed" sim.log && exit 1 || exit 0
